/* lc4_pkg.sv */
package lc4_pkg;

   localparam int XLEN      = 16;   // data and address width
   localparam int REG_SEL_W = 3;    // eight registers

   // first fetch after reset
   localparam logic [XLEN-1:0] RESET_PC = 16'h8200;

   // opcodes of the supported subset, everything else retires as a nop
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_LDR   = 4'b0110;
   localparam logic [3:0] OP_STR   = 4'b0111;
   localparam logic [3:0] OP_CONST = 4'b1001;

   localparam logic [2:0] SUB_ADD = 3'b000;   // under OP_ARITH
   localparam logic [2:0] SUB_SUB = 3'b010;   // under OP_ARITH
   localparam logic [2:0] SUB_AND = 3'b000;   // under OP_LOGIC

   typedef enum logic [1:0] {
      ALU_ADD    = 2'd0,
      ALU_SUB    = 2'd1,
      ALU_AND    = 2'd2,
      ALU_PASS_B = 2'd3    // CONST, operand b straight through
   } alu_op_e;

   // register form, ADD/SUB/AND
   typedef struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic [2:0]           subop;
      logic [REG_SEL_W-1:0] rt;
   } insn_reg_t;

   // immediate form, ADD imm, LDR, STR, CONST
   typedef struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;     // data register for STR
      logic [REG_SEL_W-1:0] rs;     // upper imm9 bits for CONST
      logic [5:0]           imm6;   // bit 5 set marks ADD immediate
   } insn_imm_t;

   // one instruction word, two ways to read it
   typedef union packed {
      insn_reg_t r;
      insn_imm_t i;
   } insn_t;

endpackage

/* lc4_decoder.sv */
module lc4_decoder (
   input  lc4_pkg::insn_t                i_insn,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rs_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rt_sel,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rd_sel,
   output logic                          o_rs_re,
   output logic                          o_rt_re,
   output logic                          o_reg_we,
   output logic                          o_is_load,
   output logic                          o_is_store,
   output lc4_pkg::alu_op_e              o_alu_op,
   output logic                          o_use_imm,
   output logic [lc4_pkg::XLEN-1:0]      o_imm
);

   logic [8:0] imm9;

   assign imm9 = {i_insn.i.rs, i_insn.i.imm6};

   // register selects come straight from the fields
   assign o_rs_sel = i_insn.r.rs;
   assign o_rd_sel = i_insn.r.rd;
   assign o_rt_sel = (i_insn.i.opcode == lc4_pkg::OP_STR) ? i_insn.i.rd : i_insn.r.rt;

   always_comb begin
      o_rs_re    = 1'b0;
      o_rt_re    = 1'b0;
      o_reg_we   = 1'b0;
      o_is_load  = 1'b0;
      o_is_store = 1'b0;
      o_use_imm  = 1'b0;
      o_alu_op   = lc4_pkg::ALU_ADD;
      o_imm      = {{(lc4_pkg::XLEN-6){i_insn.i.imm6[5]}}, i_insn.i.imm6};

      case (i_insn.r.opcode)
         lc4_pkg::OP_ARITH: begin
            if (i_insn.i.imm6[5]) begin   // ADD rd, rs, imm5
               o_rs_re   = 1'b1;
               o_reg_we  = 1'b1;
               o_use_imm = 1'b1;
               o_imm     = {{(lc4_pkg::XLEN-5){i_insn.i.imm6[4]}}, i_insn.i.imm6[4:0]};
            end else if (i_insn.r.subop == lc4_pkg::SUB_ADD ||
                         i_insn.r.subop == lc4_pkg::SUB_SUB) begin
               o_rs_re  = 1'b1;
               o_rt_re  = 1'b1;
               o_reg_we = 1'b1;
               o_alu_op = (i_insn.r.subop == lc4_pkg::SUB_SUB) ? lc4_pkg::ALU_SUB
                                                               : lc4_pkg::ALU_ADD;
            end
            // MUL and DIV fall through as nops
         end
         lc4_pkg::OP_LOGIC: begin
            if (i_insn.r.subop == lc4_pkg::SUB_AND) begin   // register AND only
               o_rs_re  = 1'b1;
               o_rt_re  = 1'b1;
               o_reg_we = 1'b1;
               o_alu_op = lc4_pkg::ALU_AND;
            end
         end
         lc4_pkg::OP_LDR: begin
            o_rs_re   = 1'b1;
            o_reg_we  = 1'b1;
            o_is_load = 1'b1;
            o_use_imm = 1'b1;   // address = rs + imm6
         end
         lc4_pkg::OP_STR: begin
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;   // data register sits in rd field
            o_is_store = 1'b1;
            o_use_imm  = 1'b1;
         end
         lc4_pkg::OP_CONST: begin
            o_reg_we  = 1'b1;
            o_use_imm = 1'b1;
            o_alu_op  = lc4_pkg::ALU_PASS_B;
            o_imm     = {{(lc4_pkg::XLEN-9){imm9[8]}}, imm9};
         end
         default: ;   // nop with all enables low
      endcase
   end

endmodule

/* lc4_regfile.sv */
module lc4_regfile (
   input  logic                          gwe,
   input  logic                          i_rst_n,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd_sel,
   input  logic                          i_rd_we,
   input  logic [lc4_pkg::XLEN-1:0]      i_wdata,
   output logic [lc4_pkg::XLEN-1:0]      o_rs_data,
   output logic [lc4_pkg::XLEN-1:0]      o_rt_data
);

   localparam int NREGS = 2 ** lc4_pkg::REG_SEL_W;

   logic [lc4_pkg::XLEN-1:0] regs [NREGS];
   logic                     rs_hit;
   logic                     rt_hit;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // same-cycle write shows up on the read ports
   assign rs_hit = i_rd_we && (i_rd_sel == i_rs_sel);
   assign rt_hit = i_rd_we && (i_rd_sel == i_rt_sel);

   assign o_rs_data = rs_hit ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = rt_hit ? i_wdata : regs[i_rt_sel];

endmodule

/* lc4_execute.sv */
module lc4_execute (
   // X stage operands
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt_sel,
   input  logic [lc4_pkg::XLEN-1:0]      i_rs_data,
   input  logic [lc4_pkg::XLEN-1:0]      i_rt_data,
   input  lc4_pkg::alu_op_e              i_alu_op,
   input  logic                          i_use_imm,
   input  logic [lc4_pkg::XLEN-1:0]      i_imm,
   // M stage, older by one
   input  logic [lc4_pkg::XLEN-1:0]      i_m_result,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_m_rd_sel,
   input  logic                          i_m_reg_we,
   input  logic                          i_m_is_load,
   // W stage, older by two
   input  logic [lc4_pkg::XLEN-1:0]      i_w_data,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_w_rd_sel,
   input  logic                          i_w_reg_we,
   output logic [lc4_pkg::XLEN-1:0]      o_result,
   output logic [lc4_pkg::XLEN-1:0]      o_rt_fwd
);

   logic                     m_fwd_ok;
   logic                     rs_from_m;
   logic                     rt_from_m;
   logic                     rs_from_w;
   logic                     rt_from_w;
   logic [lc4_pkg::XLEN-1:0] op_a;
   logic [lc4_pkg::XLEN-1:0] op_b;

   // a load in M has no data yet, the hazard unit covers that case
   assign m_fwd_ok  = i_m_reg_we && !i_m_is_load;

   assign rs_from_m = m_fwd_ok && (i_m_rd_sel == i_rs_sel);
   assign rt_from_m = m_fwd_ok && (i_m_rd_sel == i_rt_sel);
   assign rs_from_w = i_w_reg_we && (i_w_rd_sel == i_rs_sel);
   assign rt_from_w = i_w_reg_we && (i_w_rd_sel == i_rt_sel);

   // newest producer wins
   always_comb begin
      if (rs_from_m) begin
         op_a = i_m_result;
      end else if (rs_from_w) begin
         op_a = i_w_data;
      end else begin
         op_a = i_rs_data;
      end

      if (rt_from_m) begin
         o_rt_fwd = i_m_result;
      end else if (rt_from_w) begin
         o_rt_fwd = i_w_data;
      end else begin
         o_rt_fwd = i_rt_data;
      end
   end

   assign op_b = i_use_imm ? i_imm : o_rt_fwd;   // store data keeps rt

   always_comb begin
      case (i_alu_op)
         lc4_pkg::ALU_ADD: o_result = op_a + op_b;   // also load/store address
         lc4_pkg::ALU_SUB: o_result = op_a - op_b;
         lc4_pkg::ALU_AND: o_result = op_a & op_b;
         default:          o_result = op_b;
      endcase
   end

endmodule

/* lc4_hazard_unit.sv */
module lc4_hazard_unit (
   input  logic                          gwe,
   input  logic                          i_rst_n,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rs_sel,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rt_sel,
   input  logic                          i_d_rs_re,
   input  logic                          i_d_rt_re,
   input  logic                          i_x_is_load,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_x_rd_sel,
   output logic                          o_stall
);

   logic rs_dep;
   logic rt_dep;

   assign rs_dep = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
   // rt_re is also set for a store's data register
   assign rt_dep = i_d_rt_re && (i_d_rt_sel == i_x_rd_sel);

   // load result only exists after M, hold D one cycle
   assign o_stall = i_x_is_load && (rs_dep || rt_dep);

   // X is a bubble throughout reset
   a_no_stall_in_reset: assert property (
      @(posedge gwe) !i_rst_n |-> !o_stall
   ) else $error("stall raised while reset is held");

   // the bubble pushed into X removes the load, so one cycle is enough
   a_single_cycle_stall: assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      o_stall |=> !o_stall
   ) else $error("load-use stall lasted two cycles");

endmodule

/* lc4_pipeline.sv */
module lc4_pipeline (
   input  logic                     gwe,
   input  logic                     i_rst_n,
   output logic [lc4_pkg::XLEN-1:0] o_imem_addr,
   input  logic [lc4_pkg::XLEN-1:0] i_imem_data,
   output logic [lc4_pkg::XLEN-1:0] o_dmem_addr,
   output logic                     o_dmem_we,
   output logic [lc4_pkg::XLEN-1:0] o_dmem_wdata,
   input  logic [lc4_pkg::XLEN-1:0] i_dmem_rdata
);

   logic [lc4_pkg::XLEN-1:0]      pc;
   logic                          stall;

   // decode stage
   lc4_pkg::insn_t                d_insn;
   logic [lc4_pkg::REG_SEL_W-1:0] dec_rs_sel, dec_rt_sel, dec_rd_sel;
   logic                          dec_rs_re, dec_rt_re, dec_reg_we;
   logic                          dec_is_load, dec_is_store, dec_use_imm;
   lc4_pkg::alu_op_e              dec_alu_op;
   logic [lc4_pkg::XLEN-1:0]      dec_imm;
   logic [lc4_pkg::XLEN-1:0]      rf_rs_data, rf_rt_data;

   // execute stage
   logic [lc4_pkg::REG_SEL_W-1:0] x_rs_sel, x_rt_sel, x_rd_sel;
   logic [lc4_pkg::XLEN-1:0]      x_rs_data, x_rt_data, x_imm;
   lc4_pkg::alu_op_e              x_alu_op;
   logic                          x_use_imm, x_reg_we, x_is_load, x_is_store;
   logic [lc4_pkg::XLEN-1:0]      ex_result, ex_rt_fwd;

   // memory stage
   logic [lc4_pkg::XLEN-1:0]      m_result, m_rt_data;
   logic [lc4_pkg::REG_SEL_W-1:0] m_rd_sel;
   logic                          m_reg_we, m_is_load, m_is_store;

   // writeback stage
   logic [lc4_pkg::XLEN-1:0]      w_result, w_load_data, w_data;
   logic [lc4_pkg::REG_SEL_W-1:0] w_rd_sel;
   logic                          w_reg_we, w_is_load;

   // fetch, PC and D both hold on a load-use stall
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc     <= lc4_pkg::RESET_PC;
         d_insn <= '0;   // all-zero word retires as nop
      end else if (!stall) begin
         pc     <= pc + lc4_pkg::XLEN'(1);
         d_insn <= i_imem_data;
      end
   end

   assign o_imem_addr = pc;

   lc4_decoder u_decoder (
      .i_insn     (d_insn),
      .o_rs_sel   (dec_rs_sel),
      .o_rt_sel   (dec_rt_sel),
      .o_rd_sel   (dec_rd_sel),
      .o_rs_re    (dec_rs_re),
      .o_rt_re    (dec_rt_re),
      .o_reg_we   (dec_reg_we),
      .o_is_load  (dec_is_load),
      .o_is_store (dec_is_store),
      .o_alu_op   (dec_alu_op),
      .o_use_imm  (dec_use_imm),
      .o_imm      (dec_imm)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (dec_rs_sel),
      .i_rt_sel  (dec_rt_sel),
      .i_rd_sel  (w_rd_sel),
      .i_rd_we   (w_reg_we),
      .i_wdata   (w_data),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   lc4_hazard_unit u_hazard_unit (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_d_rs_sel  (dec_rs_sel),
      .i_d_rt_sel  (dec_rt_sel),
      .i_d_rs_re   (dec_rs_re),
      .i_d_rt_re   (dec_rt_re),
      .i_x_is_load (x_is_load),
      .i_x_rd_sel  (x_rd_sel),
      .o_stall     (stall)
   );

   // X control, a stall turns the slot into a bubble
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         x_reg_we   <= 1'b0;
         x_is_load  <= 1'b0;
         x_is_store <= 1'b0;
      end else begin
         x_reg_we   <= dec_reg_we && !stall;
         x_is_load  <= dec_is_load && !stall;
         x_is_store <= dec_is_store && !stall;
      end
   end

   always_ff @(posedge gwe) begin
      x_rs_sel  <= dec_rs_sel;
      x_rt_sel  <= dec_rt_sel;
      x_rd_sel  <= dec_rd_sel;
      x_rs_data <= rf_rs_data;
      x_rt_data <= rf_rt_data;
      x_alu_op  <= dec_alu_op;
      x_use_imm <= dec_use_imm;
      x_imm     <= dec_imm;
   end

   lc4_execute u_execute (
      .i_rs_sel    (x_rs_sel),
      .i_rt_sel    (x_rt_sel),
      .i_rs_data   (x_rs_data),
      .i_rt_data   (x_rt_data),
      .i_alu_op    (x_alu_op),
      .i_use_imm   (x_use_imm),
      .i_imm       (x_imm),
      .i_m_result  (m_result),
      .i_m_rd_sel  (m_rd_sel),
      .i_m_reg_we  (m_reg_we),
      .i_m_is_load (m_is_load),
      .i_w_data    (w_data),
      .i_w_rd_sel  (w_rd_sel),
      .i_w_reg_we  (w_reg_we),
      .o_result    (ex_result),
      .o_rt_fwd    (ex_rt_fwd)
   );

   // M and W control
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         m_reg_we   <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
         w_reg_we   <= 1'b0;
         w_is_load  <= 1'b0;
      end else begin
         m_reg_we   <= x_reg_we;
         m_is_load  <= x_is_load;
         m_is_store <= x_is_store;
         w_reg_we   <= m_reg_we;
         w_is_load  <= m_is_load;
      end
   end

   always_ff @(posedge gwe) begin
      m_result    <= ex_result;
      m_rt_data   <= ex_rt_fwd;
      m_rd_sel    <= x_rd_sel;
      w_result    <= m_result;
      w_load_data <= i_dmem_rdata;   // combinational read from M address
      w_rd_sel    <= m_rd_sel;
   end

   // address is the ALU sum, data is rt
   assign o_dmem_addr  = m_result;
   assign o_dmem_we    = m_is_store;
   assign o_dmem_wdata = m_rt_data;

   assign w_data = w_is_load ? w_load_data : w_result;

endmodule

/* tb_lc4_pipeline.sv */
module tb_lc4_pipeline;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IMEM_DEPTH = 512;
   localparam int DMEM_DEPTH = 65536;
   localparam int N_RANDOM   = 200;

   logic                     gwe = 1'b0;
   logic                     i_rst_n;
   logic [lc4_pkg::XLEN-1:0] o_imem_addr, i_imem_data, imem_off;
   logic [lc4_pkg::XLEN-1:0] o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
   logic                     o_dmem_we;

   logic [15:0] imem [IMEM_DEPTH];
   logic [15:0] dmem [DMEM_DEPTH];
   logic [15:0] model_mem [DMEM_DEPTH];
   logic [15:0] prog [$];
   logic [15:0] exp_addr [$];
   logic [15:0] exp_data [$];
   logic [15:0] prev_addr;
   bit          prog_ready = 1'b0;
   bit          fetch_seen = 1'b0;
   int          hold_cnt, st_idx, err_mismatch, err_other;

   lc4_pipeline u_lc4_pipeline (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .o_imem_addr  (o_imem_addr),
      .i_imem_data  (i_imem_data),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .i_dmem_rdata (i_dmem_rdata)
   );

   always #5 gwe = ~gwe;

   // program starts at RESET_PC with zero words after it
   assign imem_off     = o_imem_addr - lc4_pkg::RESET_PC;
   assign i_imem_data  = (imem_off < 16'(IMEM_DEPTH)) ? imem[imem_off[8:0]] : '0;
   assign i_dmem_rdata = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int a = 0; a < DMEM_DEPTH; a++) begin
            dmem[a] <= 16'(a) ^ 16'hA5A5;
         end
      end else if (o_dmem_we) begin
         dmem[o_dmem_addr] <= o_dmem_wdata;
      end
   end

   function automatic logic [15:0] enc_r(logic [3:0] op, int rd, int rs,
                                         logic [2:0] sub, int rt);
      lc4_pkg::insn_t w;
      w.r = {op, 3'(rd), 3'(rs), sub, 3'(rt)};
      return w;
   endfunction

   // for CONST rs carries imm9[8:6] and imm6 carries imm9[5:0]
   function automatic logic [15:0] enc_i(logic [3:0] op, int rd, int rs, int imm6);
      lc4_pkg::insn_t w;
      w.i = {op, 3'(rd), 3'(rs), 6'(imm6)};
      return w;
   endfunction

   // in-order model of the subset that fills the store queues
   function automatic void predict_stores();
      logic [15:0]    r [8];
      lc4_pkg::insn_t w;
      logic [15:0]    a, b, ea;
      logic [2:0]     rd;
      r = '{default: '0};
      foreach (prog[n]) begin
         w  = prog[n];
         rd = w.r.rd;
         a  = r[w.r.rs];
         b  = r[w.r.rt];
         ea = a + {{10{w.i.imm6[5]}}, w.i.imm6};   // rs + imm6
         casez ({w.r.opcode, w.r.subop})
            7'b0001_1??: r[rd] = a + {{11{w.i.imm6[4]}}, w.i.imm6[4:0]};
            7'b0001_000: r[rd] = a + b;
            7'b0001_010: r[rd] = a - b;
            7'b0101_000: r[rd] = a & b;
            7'b0110_???: r[rd] = model_mem[ea];
            7'b0111_???: begin   // rd field names the data register
               model_mem[ea] = r[rd];
               exp_addr.push_back(ea);
               exp_data.push_back(r[rd]);
            end
            7'b1001_???: r[rd] = {{7{w.r.rs[2]}}, w.r.rs, w.i.imm6};
            default: ;   // nop
         endcase
      end
   endfunction

   function automatic logic [15:0] random_insn();
      int          rd, rs, rt;
      logic [15:0] w;
      rd = $urandom_range(0, 7);
      rs = $urandom_range(0, 7);
      rt = $urandom_range(0, 7);
      case ($urandom_range(0, 8))
         0: w = enc_r(lc4_pkg::OP_ARITH, rd, rs, 3'b000, rt);
         1: w = enc_r(lc4_pkg::OP_ARITH, rd, rs, 3'b010, rt);
         2: w = enc_r(lc4_pkg::OP_LOGIC, rd, rs, 3'b000, rt);
         3: w = enc_i(lc4_pkg::OP_ARITH, rd, rs, 32 + $urandom_range(0, 31));
         4: w = enc_i(lc4_pkg::OP_CONST, rd, rs, $urandom_range(0, 63));
         5, 6: w = enc_i(lc4_pkg::OP_LDR, rd, rs, $urandom_range(0, 63));
         7: w = enc_i(lc4_pkg::OP_STR, rd, rs, $urandom_range(0, 63));
         default: begin   // branch, shift or MUL words
            w = 16'($urandom());
            case (w[1:0])
               2'd0: w[15:12] = 4'b0000;
               2'd1: w[15:12] = 4'b1010;
               default: w[15:3] = {lc4_pkg::OP_ARITH, w[11:6], 3'b001};
            endcase
         end
      endcase
      return w;
   endfunction

   task automatic finish_run(input bit timed_out);
      int missing;
      missing = (st_idx < exp_addr.size()) ? exp_addr.size() - st_idx : 0;
      for (int k = st_idx; k < exp_addr.size(); k++) begin
         $display("store %0d never arrived, addr %h data %h", k, exp_addr[k], exp_data[k]);
      end
      $display("errors: %0d mismatches, %0d other, %0d missing stores",
               err_mismatch, err_other, missing);
      if (!timed_out && err_mismatch == 0 && err_other == 0 && missing == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   endtask

   initial begin
      logic [15:0] end_addr;
      i_rst_n <= 1'b0;
      void'($urandom(50883));
      // dependent ALU chain through M and W forwarding and write-through
      prog.push_back(enc_i(lc4_pkg::OP_CONST, 1, 1, 21));    // r1 = 85
      prog.push_back(enc_i(lc4_pkg::OP_CONST, 2, 7, 16));    // r2 = -48
      prog.push_back(enc_r(lc4_pkg::OP_ARITH, 3, 1, 3'b000, 2));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 3, 0, 5));
      prog.push_back(enc_i(lc4_pkg::OP_ARITH, 6, 2, 39));    // r6 = r2 + 7
      prog.push_back(enc_r(lc4_pkg::OP_ARITH, 4, 3, 3'b010, 6));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 4, 0, 6));
      prog.push_back(enc_r(lc4_pkg::OP_LOGIC, 5, 4, 3'b000, 1));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 5, 4, -2));
      prog.push_back(enc_i(lc4_pkg::OP_ARITH, 5, 5, 61));    // r5 = r5 - 3
      prog.push_back(enc_i(lc4_pkg::OP_STR, 5, 5, 1));
      prog.push_back(16'h0000);
      // CONST base registers then computed addresses
      prog.push_back(enc_i(lc4_pkg::OP_CONST, 1, 1, 0));     // r1 = 64
      prog.push_back(enc_i(lc4_pkg::OP_CONST, 2, 7, 48));    // r2 = -16
      prog.push_back(enc_i(lc4_pkg::OP_LDR, 3, 1, 2));
      prog.push_back(enc_i(lc4_pkg::OP_CONST, 6, 2, 43));    // r6 = 171
      prog.push_back(enc_i(lc4_pkg::OP_ARITH, 7, 1, 33));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 3, 2, -1));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 6, 7, -32));
      // loads directly followed by a use
      prog.push_back(enc_i(lc4_pkg::OP_LDR, 4, 1, 3));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 4, 1, 4));
      prog.push_back(enc_i(lc4_pkg::OP_LDR, 5, 1, 4));
      prog.push_back(enc_r(lc4_pkg::OP_ARITH, 6, 5, 3'b000, 5));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 6, 0, 9));
      prog.push_back(enc_i(lc4_pkg::OP_LDR, 7, 0, 9));
      prog.push_back(enc_i(lc4_pkg::OP_STR, 7, 7, 0));
      repeat (N_RANDOM) begin
         prog.push_back(random_insn());
      end
      for (int i = 0; i < IMEM_DEPTH; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : '0;
      end
      for (int a = 0; a < DMEM_DEPTH; a++) begin
         model_mem[a] = 16'(a) ^ 16'hA5A5;
      end
      predict_stores();
      end_addr   = lc4_pkg::RESET_PC + 16'(prog.size() + 10);   // past the last store
      prog_ready = 1'b1;
      repeat (10) @(posedge gwe);
      i_rst_n <= 1'b1;
      while (o_imem_addr != end_addr) begin
         @(posedge gwe);
      end
      finish_run(1'b0);
   end

   // fetch order and store checks at the rising edge
   always @(posedge gwe) begin
      if (!i_rst_n) begin
         if (o_dmem_we !== 1'b0) begin
            err_mismatch++;
            $display("mismatch at %0t: o_dmem_we expected 0 got %b", $time, o_dmem_we);
         end
      end else begin
         if (!fetch_seen) begin
            if (o_imem_addr !== lc4_pkg::RESET_PC) begin
               err_mismatch++;
               $display("mismatch at %0t: o_imem_addr expected %h got %h",
                        $time, lc4_pkg::RESET_PC, o_imem_addr);
            end
         end else if (o_imem_addr == prev_addr) begin
            hold_cnt++;   // one repeat per load-use stall
            if (hold_cnt > 1) begin
               err_other++;
               $display("fetch address %h repeated more than once at %0t", prev_addr, $time);
            end
         end else begin
            hold_cnt = 0;
            if (o_imem_addr != prev_addr + 16'd1) begin
               err_mismatch++;
               $display("mismatch at %0t: o_imem_addr expected %h got %h",
                        $time, prev_addr + 16'd1, o_imem_addr);
            end
         end
         fetch_seen = 1'b1;
         prev_addr  = o_imem_addr;
         if (o_dmem_we === 1'b1) begin
            if (st_idx >= exp_addr.size()) begin
               err_other++;
               $display("unexpected extra store to %h at %0t", o_dmem_addr, $time);
            end else begin
               if (o_dmem_addr !== exp_addr[st_idx]) begin
                  err_mismatch++;
                  $display("mismatch at %0t: o_dmem_addr expected %h got %h",
                           $time, exp_addr[st_idx], o_dmem_addr);
               end
               if (o_dmem_wdata !== exp_data[st_idx]) begin
                  err_mismatch++;
                  $display("mismatch at %0t: o_dmem_wdata expected %h got %h",
                           $time, exp_data[st_idx], o_dmem_wdata);
               end
               st_idx++;
            end
         end
      end
   end

   // room for a stall after every instruction plus reset
   initial begin
      int limit;
      wait (prog_ready);
      limit = 10 + 3 * (prog.size() + 10);
      repeat (limit) @(posedge gwe);
      $display("timeout, run did not finish within %0d cycles", limit);
      finish_run(1'b1);
   end

endmodule

/* lc4_pipeline.f */
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_execute.sv
lc4_hazard_unit.sv
lc4_pipeline.sv
tb_lc4_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_lc4_pipeline -f lc4_pipeline.f \
   --Mdir obj_dir -o sim_lc4 || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_lc4)
echo "$sim_out"
echo "$sim_out" | grep -qx "SIMULATION PASSED" && echo "run passed" \
   || { echo "run failed"; exit 1; }
